// File: ciPkg.sv
package ciPkg;

  // custom-instruction port widths
  typedef logic [31:0] ciWord_t;    // operands and result
  typedef logic [7:0]  ciNumber_t;  // instruction number, ciN

  // pixel formats
  typedef logic [15:0] rgb565_t;
  typedef logic [7:0]  gray_t;

  // default instruction numbers of the extensions
  localparam ciNumber_t swapByteNumber  = 8'd1;
  localparam ciNumber_t delayNumber     = 8'd6;
  localparam ciNumber_t profileNumber   = 8'd11;
  localparam ciNumber_t grayscaleNumber = 8'd12;

endpackage

// File: resetSequencer.sv
`timescale 1ns/1ps

module resetSequencer #(
  parameter int resetCycles = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset,
  output logic resetDone
);

  localparam int countWidth = (resetCycles > 0) ? $clog2(resetCycles + 1) : 1;
  localparam logic [countWidth-1:0] terminalCount = countWidth'(resetCycles);

  logic [countWidth-1:0] countReg;

  // saturates at the terminal count, restarts on every loss of lock
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      countReg <= '0;
    end else if (countReg != terminalCount) begin
      countReg <= countReg + 1'b1;
    end
  end

  assign resetDone = (countReg == terminalCount);  // released level
  assign cpuReset  = ~resetDone;

endmodule

// File: swapByteIse.sv
`timescale 1ns/1ps

module swapByteIse #(
  parameter ciPkg::ciNumber_t customInstructionId = ciPkg::swapByteNumber
) (
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult
);

  // answers in the start cycle
  assign ciDone = ciStart && (ciN == customInstructionId);

  // byte 0 <-> byte 3, byte 1 <-> byte 2
  assign ciResult = ciDone ? {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]}
                           : '0;

endmodule

// File: rgb565GrayscaleIse.sv
`timescale 1ns/1ps

module rgb565GrayscaleIse #(
  parameter ciPkg::ciNumber_t customInstructionId = ciPkg::grayscaleNumber
) (
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult
);

  import ciPkg::*;

  rgb565_t     pixel;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  gray_t       grayValue;

  assign pixel = ciDataA[15:0];  // upper half ignored

  // widen each channel to 8 bits
  assign red   = {pixel[15:11], 3'b000};
  assign green = {pixel[10:5], 2'b00};
  assign blue  = {pixel[4:0], 3'b000};

  // weights sum to 256, so the total fits 16 bits
  assign weightedSum = 16'(red) * 16'd54
                     + 16'(green) * 16'd183
                     + 16'(blue) * 16'd19;

  assign grayValue = weightedSum[15:8];

  assign ciDone   = ciStart && (ciN == customInstructionId);
  assign ciResult = ciDone ? ciWord_t'(grayValue) : '0;

endmodule

// File: delayIse.sv
`timescale 1ns/1ps

module delayIse #(
  parameter ciPkg::ciNumber_t customInstructionId = ciPkg::delayNumber,
  parameter int               systemClockInHz     = 74250000
) (
  input  logic             s_systemClock,
  input  logic             cpuReset,
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult
);

  import ciPkg::*;

  localparam int clocksPerUs   = systemClockInHz / 1000000;
  localparam int prescaleWidth = $clog2(clocksPerUs);

  // the start cycle already counts towards the first microsecond
  localparam logic [prescaleWidth-1:0] firstReload = prescaleWidth'(clocksPerUs - 2);
  localparam logic [prescaleWidth-1:0] usReload    = prescaleWidth'(clocksPerUs - 1);

  typedef enum logic [1:0] {
    idle,
    counting,
    finishing
  } delayState_t;

  delayState_t              stateReg;
  delayState_t              stateNext;
  ciWord_t                  usLeftReg;
  logic [prescaleWidth-1:0] prescaleReg;
  logic                     startHit;
  logic                     usTick;
  logic                     lastTick;

  assign startHit = ciStart && (ciN == customInstructionId);
  assign usTick   = (prescaleReg == '0);
  assign lastTick = usTick && (usLeftReg == ciWord_t'(1));

  always_comb begin
    stateNext = stateReg;
    case (stateReg)
      idle: begin
        if (startHit) begin
          stateNext = (ciDataA == '0) ? finishing : counting;  // zero waits one clock
        end
      end
      counting: begin
        if (lastTick) begin
          stateNext = finishing;
        end
      end
      finishing: stateNext = idle;
      default:   stateNext = idle;
    endcase
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      stateReg <= idle;
    end else begin
      stateReg <= stateNext;
    end
  end

  // microsecond prescaler and remaining count
  always_ff @(posedge s_systemClock) begin
    if (stateReg == idle) begin
      usLeftReg   <= ciDataA;
      prescaleReg <= firstReload;
    end else if (usTick) begin
      usLeftReg   <= usLeftReg - 1'b1;
      prescaleReg <= usReload;
    end else begin
      prescaleReg <= prescaleReg - 1'b1;
    end
  end

  assign ciDone   = (stateReg == finishing);
  assign ciResult = '0;  // nothing to return

endmodule

// File: profileCounterIse.sv
`timescale 1ns/1ps

module profileCounterIse #(
  parameter ciPkg::ciNumber_t customInstructionId = ciPkg::profileNumber
) (
  input  logic             s_systemClock,
  input  logic             cpuReset,
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult
);

  import ciPkg::*;

  ciWord_t cycleCountReg;
  logic    runningReg;
  logic    startCmd;
  logic    stopCmd;
  logic    clearCmd;

  assign ciDone = ciStart && (ciN == customInstructionId);

  // command bits in operand B
  assign startCmd = ciDone && ciDataB[0];
  assign stopCmd  = ciDone && ciDataB[1];
  assign clearCmd = ciDone && ciDataB[2];

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      runningReg <= 1'b0;
    end else if (stopCmd) begin
      runningReg <= 1'b0;  // stop wins over start
    end else if (startCmd) begin
      runningReg <= 1'b1;
    end
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      cycleCountReg <= '0;
    end else if (clearCmd) begin
      cycleCountReg <= '0;
    end else if (runningReg) begin
      cycleCountReg <= cycleCountReg + 1'b1;
    end
  end

  // value from before this command takes effect
  assign ciResult = ciDone ? cycleCountReg : '0;

endmodule

// File: ciBank.sv
`timescale 1ns/1ps

module ciBank #(
  parameter int systemClockInHz = 74250000,
  parameter int resetCycles     = 16
) (
  input  logic             s_systemClock,
  input  logic             s_pllLocked,
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult,
  output logic             resetDone
);

  import ciPkg::*;

  logic    s_cpuReset;
  logic    s_activeStart;
  logic    s_swapByteDone;
  logic    s_grayscaleDone;
  logic    s_delayDone;
  logic    s_profileDone;
  ciWord_t s_swapByteResult;
  ciWord_t s_grayscaleResult;
  ciWord_t s_delayResult;
  ciWord_t s_profileResult;

  resetSequencer #(
    .resetCycles(resetCycles)
  ) resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (s_cpuReset),
    .resetDone    (resetDone)
  );

  // same-cycle extensions answer straight from the start,
  // so their start is held off until the reset is released
  assign s_activeStart = ciStart & resetDone;

  swapByteIse #(
    .customInstructionId(swapByteNumber)
  ) swapByte (
    .ciStart (s_activeStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  rgb565GrayscaleIse #(
    .customInstructionId(grayscaleNumber)
  ) grayscale (
    .ciStart (s_activeStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDone  (s_grayscaleDone),
    .ciResult(s_grayscaleResult)
  );

  delayIse #(
    .customInstructionId(delayNumber),
    .systemClockInHz    (systemClockInHz)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .cpuReset     (s_cpuReset),
    .ciStart      (ciStart),  // FSM held idle in reset
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (s_delayDone),
    .ciResult     (s_delayResult)
  );

  profileCounterIse #(
    .customInstructionId(profileNumber)
  ) profiler (
    .s_systemClock(s_systemClock),
    .cpuReset     (s_cpuReset),
    .ciStart      (s_activeStart),
    .ciN          (ciN),
    .ciDataB      (ciDataB),
    .ciDone       (s_profileDone),
    .ciResult     (s_profileResult)
  );

  // idle extensions drive zero, so a plain OR merges the answers
  assign ciDone   = s_swapByteDone | s_grayscaleDone | s_delayDone | s_profileDone;
  assign ciResult = s_swapByteResult | s_grayscaleResult | s_delayResult | s_profileResult;

endmodule

// File: tbCiBank.sv
`timescale 1ns/1ps

module tbCiBank;

  import ciPkg::*;

  localparam int clockHz     = 10000000;
  localparam int clocksPerUs = clockHz / 1000000;
  localparam int resetLength = 16;

  // how the compare process treats a done
  localparam int kindWord = 0;
  localparam int kindGray = 1;
  localparam int kindFree = 2;  // value judged by the stimulus

  logic      s_systemClock = 1'b0;
  logic      s_pllLocked;
  logic      ciStart;
  ciNumber_t ciN;
  ciWord_t   ciDataA;
  ciWord_t   ciDataB;
  logic      ciDone;
  ciWord_t   ciResult;
  logic      resetDone;

  integer  seed = 32'h739d;
  int      mismatchCount = 0;
  int      otherErrors = 0;
  string   pendingName[$];
  int      pendingKind[$];
  ciWord_t pendingValue[$];

  ciBank #(
    .systemClockInHz(clockHz),
    .resetCycles    (resetLength)
  ) uut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .resetDone    (resetDone)
  );

  always #50 s_systemClock = ~s_systemClock;

  function automatic ciWord_t modelResult(ciNumber_t number, ciWord_t dataA);
    ciWord_t value;
    int      red;
    int      green;
    int      blue;
    int      k;
    value = '0;
    red   = dataA[15:11] * 8;  // 5 bits widened to 8
    green = dataA[10:5] * 4;
    blue  = dataA[4:0] * 8;
    if (number == swapByteNumber) begin
      for (k = 0; k < 4; k++) begin
        value[8*k +: 8] = dataA[8*(3-k) +: 8];
      end
    end else if (number == grayscaleNumber) begin
      value = ciWord_t'((red * 54 + green * 183 + blue * 19) >> 8);
    end
    return value;  // delay answers zero
  endfunction

  function automatic int modelLatency(ciNumber_t number, ciWord_t dataA);
    if (number != delayNumber) begin
      return 0;
    end
    if (dataA == '0) begin
      return 1;
    end
    return int'(dataA) * clocksPerUs;
  endfunction

  task automatic checkWord(input string name, input ciWord_t expected, input ciWord_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkGray(input string name, input gray_t expected, input gray_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkCycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic queueExpected(input string name, input int kind, input ciWord_t value);
    pendingName.push_back(name);
    pendingKind.push_back(kind);
    pendingValue.push_back(value);
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge s_systemClock);
      #1;
    end
  endtask

  // entered and left 1 ns after a rising edge
  task automatic execute(input string name, input ciNumber_t number, input ciWord_t dataA,
                         input ciWord_t dataB, input int maxCycles, input bit expectDone,
                         output ciWord_t result, output int latency);
    bit gotDone;
    gotDone = 1'b0;
    latency = 0;
    result  = '0;
    ciN     = number;
    ciDataA = dataA;
    ciDataB = dataB;
    ciStart = 1'b1;
    while (!gotDone && latency <= maxCycles) begin
      @(negedge s_systemClock);
      if (ciDone === 1'b1) begin
        gotDone = 1'b1;
        result  = ciResult;
      end
      @(posedge s_systemClock);
      #1;
      ciStart = 1'b0;  // one-cycle pulse
      if (!gotDone) begin
        latency++;
      end
    end
    if (expectDone && !gotDone) begin
      $display("timeout: %s gave no done within %0d cycles", name, maxCycles);
      otherErrors++;
      pendingName.delete();
      pendingKind.delete();
      pendingValue.delete();
    end else if (!expectDone && gotDone) begin
      $display("error: %s raised done although no extension owns it", name);
      otherErrors++;
    end
  endtask

  task automatic runAndCheck(input string name, input ciNumber_t number, input ciWord_t dataA,
                             input ciWord_t dataB);
    ciWord_t result;
    int      latency;
    int      expectedLatency;
    int      kind;
    expectedLatency = modelLatency(number, dataA);
    kind = (number == grayscaleNumber) ? kindGray : kindWord;
    queueExpected(name, kind, modelResult(number, dataA));
    execute(name, number, dataA, dataB, expectedLatency + 10, 1'b1, result, latency);
    checkCycles({name, " latency"}, expectedLatency, latency);
  endtask

  task automatic profileCommand(input string name, input ciWord_t command, input int kind,
                                input ciWord_t expected, output ciWord_t result);
    int latency;
    queueExpected(name, kind, expected);
    execute(name, profileNumber, '0, command, 5, 1'b1, result, latency);
    checkCycles({name, " latency"}, 0, latency);
  endtask

  // every done must match the oldest pending instruction
  always @(negedge s_systemClock) begin : compareResults
    string   name;
    int      kind;
    ciWord_t value;
    if (ciDone === 1'b1) begin
      if (pendingKind.size() == 0) begin
        $display("error: done at %0t ns with no instruction pending", $time);
        otherErrors++;
      end else begin
        name  = pendingName.pop_front();
        kind  = pendingKind.pop_front();
        value = pendingValue.pop_front();
        if (kind == kindWord) begin
          checkWord(name, value, ciResult);
        end else if (kind == kindGray) begin
          checkGray(name, gray_t'(value), ciResult[7:0]);
          checkWord({name, " upper bits"}, '0, {ciResult[31:8], 8'h00});
        end
      end
    end else if (ciDone !== 1'b0) begin
      $display("error: done is unknown at %0t ns", $time);
      otherErrors++;
    end else if (ciResult !== '0) begin
      $display("error: result %h while done is low at %0t ns", ciResult, $time);
      otherErrors++;
    end
  end

  initial begin
    int      n;
    int      latency;
    ciWord_t dataA;
    ciWord_t result;
    ciWord_t firstRead;
    ciWord_t secondRead;
    rgb565_t fixedPixels[5];
    int      delayValues[4];

    s_pllLocked    = 1'b0;
    ciStart        = 1'b0;
    ciN            = '0;
    ciDataA        = '0;
    ciDataB        = '0;
    fixedPixels    = '{16'hF800, 16'h07E0, 16'h001F, 16'hFFFF, 16'h0000};
    delayValues    = '{0, 1, 3, 7};

    // PLL unlocked with one stray start in the middle
    for (n = 0; n < 10; n++) begin
      @(posedge s_systemClock);
      #1;
      ciStart = (n == 4);
      ciN     = swapByteNumber;
      ciDataA = 32'h12345678;
      @(negedge s_systemClock);
      if (resetDone !== 1'b0) begin
        $display("error: resetDone is not low while the PLL is unlocked");
        otherErrors++;
      end
    end

    @(posedge s_systemClock);
    #1;
    ciStart     = 1'b0;
    s_pllLocked = 1'b1;
    n = 0;
    while (resetDone !== 1'b1 && n < 4 * resetLength) begin
      @(posedge s_systemClock);
      #1;
      n++;
      ciStart = (n == 3) || (n == 9);  // must be ignored
      ciN     = (n < 6) ? delayNumber : profileNumber;
      ciDataA = '0;
      ciDataB = 32'h1;
      @(negedge s_systemClock);
    end
    if (resetDone !== 1'b1) begin
      $display("timeout: resetDone never rose after the PLL locked");
      otherErrors++;
    end
    checkCycles("reset release", resetLength, n);
    @(posedge s_systemClock);
    #1;

    for (n = 0; n < 50; n++) begin
      dataA = $random(seed);
      runAndCheck($sformatf("swap %0d", n), swapByteNumber, dataA, '0);
    end

    for (n = 0; n < 5; n++) begin
      runAndCheck($sformatf("gray fixed %h", fixedPixels[n]), grayscaleNumber,
                  ciWord_t'(fixedPixels[n]), '0);
    end
    for (n = 0; n < 50; n++) begin
      dataA = $random(seed);  // upper half is noise
      runAndCheck($sformatf("gray %0d", n), grayscaleNumber, dataA, '0);
    end

    for (n = 0; n < 4; n++) begin
      runAndCheck($sformatf("delay %0d us", delayValues[n]), delayNumber,
                  ciWord_t'(delayValues[n]), '0);
    end

    profileCommand("profile clear", 32'h4, kindFree, '0, result);
    profileCommand("profile read after clear", 32'h0, kindWord, '0, result);
    profileCommand("profile start", 32'h1, kindFree, '0, result);
    profileCommand("profile running read 1", 32'h0, kindFree, '0, firstRead);
    idleCycles(5);
    profileCommand("profile running read 2", 32'h0, kindFree, '0, secondRead);
    if (secondRead <= firstRead) begin
      $display("error: profile count did not advance while running (%0d then %0d)",
               firstRead, secondRead);
      otherErrors++;
    end
    profileCommand("profile stop", 32'h2, kindFree, '0, result);
    profileCommand("profile stopped read 1", 32'h0, kindFree, '0, firstRead);
    idleCycles(5);
    profileCommand("profile stopped read 2", 32'h0, kindFree, '0, secondRead);
    checkWord("profile stopped reads", firstRead, secondRead);

    // count is nonzero here, so the clear has something to remove
    profileCommand("profile clear after stop", 32'h4, kindFree, '0, result);
    profileCommand("profile read after second clear", 32'h0, kindWord, '0, result);

    dataA = $random(seed);
    execute("unknown number 200", 8'd200, dataA, dataA, 100, 1'b0, result, latency);

    idleCycles(2);
    if (pendingKind.size() != 0) begin
      $display("error: %0d instructions never answered", pendingKind.size());
      otherErrors++;
    end

    $display("summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
    if (mismatchCount + otherErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: ciBank.f
ciPkg.sv
resetSequencer.sv
swapByteIse.sv
rgb565GrayscaleIse.sv
delayIse.sv
profileCounterIse.sv
ciBank.sv
tbCiBank.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = tbCiBank
FILELIST  = ciBank.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM       = $(BUILD_DIR)/V$(TOP)
FAIL_TEXT = CHECKS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
